// File: src/fm_settings.svh
// Sizes and pipeline delays of the FM operator core, included by RTL and testbench
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Slots served round robin, one per clock
`define FM_SLOTS   8
`define FM_SLOT_W  3

// Phase accumulator and the phase bits the operator sees
`define FM_PHASE_W 20
`define FM_PH_W    10

// Attenuation in steps of 6 dB / 32
`define FM_ATT_W   10

// Signed operator sample
`define FM_OUT_W   14

// Operator latency from input to output
`define FM_OP_LAT  6

// Own output back in step with the same slot's next pass
`define FM_FB_DLY  (`FM_SLOTS - `FM_OP_LAT)
// Previous slot's output lands one slot later
`define FM_MOD_DLY (`FM_FB_DLY + 1)

// AXI4-Lite byte address
`define FM_ADDR_W  8

`endif

// File: src/fm_pkg.sv
// Data types shared by the FM operator core, imported by the RTL modules and the testbench
`include "fm_settings.svh"

package fm_pkg;

    // Operator output, two's complement
    typedef logic signed [`FM_OUT_W-1:0] sample_t;

    // Operator phase, one full sine period
    typedef logic [`FM_PH_W-1:0] phase_t;

    // Log attenuation, all ones is silent
    typedef logic [`FM_ATT_W-1:0] atten_t;

    // Slot index
    typedef logic [`FM_SLOT_W-1:0] slot_t;

    // Self-feedback level, zero means off
    typedef logic [2:0] fb_t;

    // Per-slot phase increment, same width as the accumulator
    typedef logic [`FM_PHASE_W-1:0] phase_inc_t;

    // Address of the 256-entry ROMs
    typedef logic [7:0] rom_addr_t;

endpackage

// File: src/fm_delay_line.sv
// Reset-cleared shift register for any payload type, used for sample buffers and pipeline tags
`timescale 1ns/1ns

module fm_delay_line import fm_pkg::*; #(
    parameter type payload_t = sample_t,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);
    // Stage 0 takes din, last stage drives dout
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[DEPTH-1];
endmodule

// File: src/fm_logsin_rom.sv
// Quarter-wave log-sine ROM in 1/256 octave units, data one clock after the address
`timescale 1ns/1ns

module fm_logsin_rom import fm_pkg::*; (
    input  logic        clk,
    input  rom_addr_t   addr,
    output logic [11:0] logsin
);
    localparam real PI = 3.14159265358979;

    logic [11:0] rom_q [256];

    // Minus log2 of the sine at the middle of step i
    function automatic logic [11:0] logsin_entry(input int i);
        real s;
        s = $sin((real'(i) + 0.5) * PI / 512.0);
        return 12'($rtoi(-$ln(s) / $ln(2.0) * 256.0 + 0.5));
    endfunction

    // Filled once at elaboration
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom_q[i] = logsin_entry(i);
        end
    end

    // Smallest entries near the peak, largest near zero crossing
    always_ff @(posedge clk) begin
        logsin <= rom_q[addr];
    end
endmodule

// File: src/fm_exp_rom.sv
// Exponential ROM giving the linear mantissa of a log attenuation, data one clock later
`timescale 1ns/1ns

module fm_exp_rom import fm_pkg::*; (
    input  logic       clk,
    input  rom_addr_t  addr,
    output logic [9:0] mant
);
    logic [9:0] rom_q [256];

    // 1024 * 2^-((i+1)/256), runs from 1021 down to 512
    function automatic logic [9:0] exp_entry(input int i);
        real v;
        v = 1024.0 * $pow(2.0, -(real'(i) + 1.0) / 256.0);
        return 10'($rtoi(v + 0.5));
    endfunction

    // Filled once at elaboration
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom_q[i] = exp_entry(i);
        end
    end

    always_ff @(posedge clk) begin
        mant <= rom_q[addr];
    end
endmodule

// File: src/fm_phase_gen.sv
// Per-slot phase accumulators, advanced in slot order and presented one clock later
`timescale 1ns/1ns
`include "fm_settings.svh"

module fm_phase_gen import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  slot_t      slot,
    input  phase_inc_t phase_inc,
    output phase_t     phase,
    output slot_t      phase_slot,
    output logic       phase_valid
);
    // One accumulator per slot
    phase_inc_t acc_q [`FM_SLOTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                acc_q[i] <= '0;
            end
            phase       <= '0;
            phase_slot  <= '0;
            phase_valid <= 1'b0;
        end else begin
            // Wraps freely, only the top bits reach the operator
            acc_q[slot] <= acc_q[slot] + phase_inc;
            // Value before this pass's increment
            phase       <= acc_q[slot][`FM_PHASE_W-1 -: `FM_PH_W];
            phase_slot  <= slot;
            // Every clock carries a slot once out of reset
            phase_valid <= 1'b1;
        end
    end
endmodule

// File: src/fm_operator.sv
// Pipelined FM operator shared by all slots, one sample in and out per clock
`timescale 1ns/1ns
`include "fm_settings.svh"

module fm_operator import fm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  slot_t   in_slot,
    input  phase_t  phase,
    input  atten_t  atten,
    input  fb_t     fb,
    input  logic    mod_en,
    input  sample_t fb_prev1,
    input  sample_t fb_prev2,
    input  sample_t mod_in,
    output logic    out_valid,
    output slot_t   out_slot,
    output sample_t out_sample
);
    // Sign leaves stage 1 and is needed by the last stage
    localparam int SIGN_DLY = `FM_OP_LAT - 2;
    // Attenuation meets the log-sine value two clocks in
    localparam int ATT_DLY  = 2;

    logic signed [`FM_OUT_W:0] fb_sum;
    logic signed [`FM_OUT_W:0] pm_term;
    logic [3:0]                fb_shift;
    phase_t                    ph1;
    rom_addr_t                 ls_addr;
    logic [11:0]               logsin2;
    atten_t                    atten2;
    logic [13:0]               att_sum;
    logic [11:0]               att3;
    logic [9:0]                mant4;
    logic [3:0]                exp4;
    logic [`FM_OUT_W-2:0]      mag5;
    sample_t                   mag_s;
    logic                      sign5;

    // Stage 1: phase modulation
    always_comb begin
        // Sum of the slot's last two outputs, one bit wider
        fb_sum   = fb_prev1 + fb_prev2;
        fb_shift = 4'd10 - 4'(fb);
        if (fb != '0) begin
            pm_term = fb_sum >>> fb_shift;
        end else if (mod_en) begin
            // Previous slot's output as the modulator
            pm_term = mod_in >>> 2;
        end else begin
            pm_term = '0;
        end
    end

    // Upper bits of the term drop off, phase wraps
    always_ff @(posedge clk) begin
        ph1 <= phase + pm_term[`FM_PH_W-1:0];
    end

    // Stage 2: log-sine lookup
    // Second quarter of each half reads the table backwards
    assign ls_addr = ph1[8] ? ~ph1[7:0] : ph1[7:0];

    fm_logsin_rom i_logsin (
        .clk    (clk),
        .addr   (ls_addr),
        .logsin (logsin2)
    );

    fm_delay_line #(.payload_t(atten_t), .DEPTH(ATT_DLY)) i_att_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (atten),
        .dout  (atten2)
    );

    // Stage 3: total attenuation
    // One attenuation step is 8 log-sine steps
    assign att_sum = 14'(logsin2) + 14'({atten2, 3'b000});

    // Saturate at the 12-bit maximum
    always_ff @(posedge clk) begin
        att3 <= (att_sum > 14'd4095) ? 12'hfff : att_sum[11:0];
    end

    // Stage 4: exponential lookup on the fraction
    fm_exp_rom i_exp (
        .clk  (clk),
        .addr (att3[7:0]),
        .mant (mant4)
    );

    always_ff @(posedge clk) begin
        exp4 <= att3[11:8];
    end

    // Stage 5: octave shift, full scale just under 2^13
    always_ff @(posedge clk) begin
        mag5 <= {mant4, 3'b000} >> exp4;
    end

    // Stage 6: sign restore
    assign mag_s = sample_t'(mag5);

    always_ff @(posedge clk) begin
        out_sample <= sign5 ? -mag_s : mag_s;
    end

    // Upper half of the sine period is negative
    fm_delay_line #(.payload_t(logic), .DEPTH(SIGN_DLY)) i_sign_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (ph1[`FM_PH_W-1]),
        .dout  (sign5)
    );

    // Slot tag and valid ride alongside the data
    fm_delay_line #(.payload_t(slot_t), .DEPTH(`FM_OP_LAT)) i_slot_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (in_slot),
        .dout  (out_slot)
    );

    fm_delay_line #(.payload_t(logic), .DEPTH(`FM_OP_LAT)) i_valid_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (in_valid),
        .dout  (out_valid)
    );
endmodule

// File: src/fm_regs_axil.sv
// AXI4-Lite register bank with per-slot settings and the latest sample of each slot
`timescale 1ns/1ns
`include "fm_settings.svh"

module fm_regs_axil import fm_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`FM_ADDR_W-1:0] s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [31:0]           s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    output logic [1:0]            s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    input  logic [`FM_ADDR_W-1:0] s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    output logic [31:0]           s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    input  slot_t                 slot,
    output phase_inc_t            phase_inc,
    output atten_t                atten,
    output fb_t                   fb,
    output logic                  mod_en,
    input  logic                  smp_valid,
    input  slot_t                 smp_slot,
    input  sample_t               smp
);
    phase_inc_t inc_q [`FM_SLOTS];
    atten_t     att_q [`FM_SLOTS];
    fb_t        fb_q  [`FM_SLOTS];
    logic       mod_q [`FM_SLOTS];
    sample_t    smp_q [`FM_SLOTS];

    logic                  aw_fire, w_fire, ar_fire;
    logic                  aw_hold, w_hold;
    logic                  aw_have, w_have, do_write, wr_map;
    logic                  bvalid_next, rvalid_next;
    logic [`FM_ADDR_W-1:0] aw_addr_q, wr_addr;
    logic [31:0]           w_data_q, wr_data, wr_word;
    logic [3:0]            w_strb_q, wr_strb;
    slot_t                 wr_slot;

    // Word at a byte address, 16 bytes per slot, zero past the map
    function automatic logic [31:0] reg_word(input logic [`FM_ADDR_W-1:0] a);
        slot_t       s;
        logic [31:0] w;
        s = a[`FM_SLOT_W+3:4];
        w = '0;
        if (int'(a) < `FM_SLOTS * 16) begin
            case (a[3:2])
                2'd0:    w = 32'(inc_q[s]);
                2'd1:    w = 32'(att_q[s]);
                2'd2:    w = 32'({mod_q[s], 5'd0, fb_q[s]});
                // Sample is sign-extended
                default: w = 32'(smp_q[s]);
            endcase
        end
        return w;
    endfunction

    assign aw_fire = s_axil_awvalid && s_axil_awready;
    assign w_fire  = s_axil_wvalid && s_axil_wready;
    assign ar_fire = s_axil_arvalid && s_axil_arready;

    // Address and data may come in either order
    assign aw_have  = aw_hold || aw_fire;
    assign w_have   = w_hold || w_fire;
    assign do_write = aw_have && w_have;
    assign wr_addr  = aw_fire ? s_axil_awaddr : aw_addr_q;
    assign wr_data  = w_fire ? s_axil_wdata : w_data_q;
    assign wr_strb  = w_fire ? s_axil_wstrb : w_strb_q;
    assign wr_slot  = wr_addr[`FM_SLOT_W+3:4];
    assign wr_map   = int'(wr_addr) < `FM_SLOTS * 16;

    assign bvalid_next = do_write || (s_axil_bvalid && !s_axil_bready);
    assign rvalid_next = ar_fire || (s_axil_rvalid && !s_axil_rready);

    // Strobed bytes over the current contents
    always_comb begin
        wr_word = reg_word(wr_addr);
        for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) begin
                wr_word[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
    end

    // Handshake; no new request while a response is pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_hold        <= 1'b0;
            w_hold         <= 1'b0;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            aw_hold        <= aw_have && !do_write;
            w_hold         <= w_have && !do_write;
            s_axil_awready <= !aw_have && !bvalid_next;
            s_axil_wready  <= !w_have && !bvalid_next;
            s_axil_bvalid  <= bvalid_next;
            s_axil_arready <= !rvalid_next;
            s_axil_rvalid  <= rvalid_next;
        end
    end

    // Slot settings, silent after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                inc_q[i] <= '0;
                att_q[i] <= '1;
                fb_q[i]  <= '0;
                mod_q[i] <= 1'b0;
            end
        end else if (do_write && wr_map) begin
            // Sample word is read-only
            case (wr_addr[3:2])
                2'd0: inc_q[wr_slot] <= wr_word[`FM_PHASE_W-1:0];
                2'd1: att_q[wr_slot] <= wr_word[`FM_ATT_W-1:0];
                2'd2: begin
                    fb_q[wr_slot]  <= wr_word[2:0];
                    mod_q[wr_slot] <= wr_word[8];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= s_axil_awaddr;
        end
        if (w_fire) begin
            w_data_q <= s_axil_wdata;
            w_strb_q <= s_axil_wstrb;
        end
        if (ar_fire) begin
            s_axil_rdata <= reg_word(s_axil_araddr);
        end
        if (smp_valid) begin
            smp_q[smp_slot] <= smp;
        end
        // One clock behind the slot, in step with its phase
        atten  <= att_q[slot];
        fb     <= fb_q[slot];
        mod_en <= mod_q[slot];
    end

    // Increment goes to the accumulator in the slot's own cycle
    assign phase_inc = inc_q[slot];

    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;
endmodule

// File: src/fm_core_top.sv
// FM operator core top level with host registers, phase generator, operator and sample buffers
`timescale 1ns/1ns
`include "fm_settings.svh"

module fm_core_top import fm_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`FM_ADDR_W-1:0] s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [31:0]           s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    output logic [1:0]            s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    input  logic [`FM_ADDR_W-1:0] s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    output logic [31:0]           s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic                  sample_valid,
    output slot_t                 sample_slot,
    output sample_t               sample
);
    slot_t      slot;
    phase_inc_t phase_inc;
    atten_t     atten;
    fb_t        fb;
    logic       mod_en;
    phase_t     phase;
    slot_t      phase_slot;
    logic       phase_valid;
    sample_t    fb_prev1;
    sample_t    fb_prev2;
    sample_t    mod_in;

    // Round-robin slot counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else begin
            slot <= (slot == slot_t'(`FM_SLOTS - 1)) ? '0 : slot + 1'b1;
        end
    end

    // Streamed samples also land in the sample registers
    fm_regs_axil i_regs (
        .*,
        .smp_valid (sample_valid),
        .smp_slot  (sample_slot),
        .smp       (sample)
    );

    fm_phase_gen i_phase (.*);

    fm_operator i_op (
        .*,
        .in_valid   (phase_valid),
        .in_slot    (phase_slot),
        .out_valid  (sample_valid),
        .out_slot   (sample_slot),
        .out_sample (sample)
    );

    // Slot's own last output, back for its next pass
    fm_delay_line #(.payload_t(sample_t), .DEPTH(`FM_FB_DLY)) i_fb1_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (sample),
        .dout  (fb_prev1)
    );

    // One full pass older
    fm_delay_line #(.payload_t(sample_t), .DEPTH(`FM_SLOTS)) i_fb2_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (fb_prev1),
        .dout  (fb_prev2)
    );

    // Output of the slot just before, one clock further on
    fm_delay_line #(.payload_t(sample_t), .DEPTH(`FM_MOD_DLY)) i_mod_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (sample),
        .dout  (mod_in)
    );
endmodule

// File: verif/fm_core_asserts.sv
// Concurrent checks on AXI4-Lite handshakes and sample stream timing, bound into the core top
`timescale 1ns/1ns

module fm_core_asserts import fm_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  s_axil_awvalid,
    input logic  s_axil_awready,
    input logic  s_axil_wvalid,
    input logic  s_axil_wready,
    input logic  s_axil_bvalid,
    input logic  s_axil_bready,
    input logic  s_axil_arvalid,
    input logic  s_axil_arready,
    input logic  s_axil_rvalid,
    input logic  s_axil_rready,
    input logic  sample_valid,
    input slot_t sample_slot
);
    // Valid held until the handshake completes
    aw_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_awvalid && !s_axil_awready |=> s_axil_awvalid)
        else $error("awvalid dropped before awready");
    w_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_wvalid && !s_axil_wready |=> s_axil_wvalid)
        else $error("wvalid dropped before wready");
    b_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");
    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_arvalid && !s_axil_arready |=> s_axil_arvalid)
        else $error("arvalid dropped before arready");
    r_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

    // Stream runs every clock once started, slots in order
    stream_on_a: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> sample_valid)
        else $error("sample_valid fell after rising");
    stream_slot_a: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> sample_slot == slot_t'($past(sample_slot) + 3'd1))
        else $error("sample_slot out of order");
endmodule

bind fm_core_top fm_core_asserts i_asserts (.*);

// File: verif/fm_core_tb.sv
// Directed testbench for the FM core: AXI master, per-pass reference model and stream checks
`timescale 1ns/1ns
`include "fm_settings.svh"

module fm_core_tb import fm_pkg::*; ();
    localparam real PI       = 3.14159265358979;
    localparam int  MAX_PASS = 20480;
    localparam int  MAX_CYC  = 20000;

    logic                  clk;
    logic                  rst_n;
    logic [`FM_ADDR_W-1:0] awaddr, araddr;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    logic [31:0]           wdata, rdata;
    logic [3:0]            wstrb;
    logic [1:0]            bresp, rresp;
    logic                  sample_valid;
    slot_t                 sample_slot;
    sample_t               sample;

    // Reference model state, mirrors what the host has written
    logic [`FM_PHASE_W-1:0] acc_m [`FM_SLOTS];
    logic [`FM_PHASE_W-1:0] inc_m [`FM_SLOTS];
    int      att_m [`FM_SLOTS];
    int      fb_m  [`FM_SLOTS];
    int      mod_m [`FM_SLOTS];
    sample_t exp_by_pass [MAX_PASS];
    sample_t got_by_pass [MAX_PASS];
    int      phase_by_pass [MAX_PASS];
    int      pass_n, out_n, m_slot, m_ph, cyc;
    int      errors, tests_ok, tests_bad;
    logic [31:0] rng;

    fm_core_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
        .s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
        .s_axil_wready(wready), .s_axil_bresp(bresp), .s_axil_bvalid(bvalid),
        .s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
        .s_axil_arready(arready), .s_axil_rdata(rdata), .s_axil_rresp(rresp),
        .s_axil_rvalid(rvalid), .s_axil_rready(rready),
        .sample_valid(sample_valid), .sample_slot(sample_slot), .sample(sample)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sine through log-sine, attenuation and exponential formulas
    function automatic sample_t ref_sample(input int ph, input int att);
        int  a, ls, tot, mant, mag;
        real s;
        a = ph & 255;
        if ((ph & 256) != 0) a = 255 - a;
        s = $sin((real'(a) + 0.5) * PI / 512.0);
        ls = $rtoi(-$ln(s) / $ln(2.0) * 256.0 + 0.5);
        tot = ls + att * 8;
        if (tot > 4095) tot = 4095;
        mant = $rtoi(1024.0 * $pow(2.0, -(real'(tot % 256) + 1.0) / 256.0) + 0.5);
        mag = (mant * 8) >> (tot / 256);
        return ((ph & 512) != 0) ? sample_t'(-mag) : sample_t'(mag);
    endfunction

    // Phase after feedback or modulation; own outputs 8 and 16 passes back
    function automatic int mod_phase(input int n, input int ph, input int fb, input int md);
        int p1, p2, m, pm;
        p1 = (n > 8) ? int'(exp_by_pass[n-8]) : 0;
        p2 = (n > 16) ? int'(exp_by_pass[n-16]) : 0;
        // Previous slot's latest finished pass
        m  = (n > 9) ? int'(exp_by_pass[n-9]) : 0;
        if (fb != 0) pm = (p1 + p2) >>> (10 - fb);
        else if (md != 0) pm = m >>> 2;
        else pm = 0;
        return (ph + pm) & 1023;
    endfunction

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        int d;
        d = int'(got) - int'(exp);
        if (d > 2 || d < -2 || $isunknown(got)) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_slot(input slot_t got, input slot_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // One pass per clock, same order as the DUT slot counter
    always @(posedge clk) begin
        if (rst_n) begin
            pass_n = pass_n + 1;
            m_slot = (pass_n - 1) % `FM_SLOTS;
            m_ph = int'(acc_m[m_slot] >> (`FM_PHASE_W - `FM_PH_W));
            acc_m[m_slot] = acc_m[m_slot] + inc_m[m_slot];
            phase_by_pass[pass_n] = mod_phase(pass_n, m_ph, fb_m[m_slot], mod_m[m_slot]);
            exp_by_pass[pass_n] = ref_sample(phase_by_pass[pass_n], att_m[m_slot]);
        end
    end

    // Every streamed sample against its pass
    always @(negedge clk) begin
        if (sample_valid) begin
            out_n = out_n + 1;
            got_by_pass[out_n] = sample;
            check_slot(sample_slot, slot_t'((out_n - 1) % `FM_SLOTS), "stream slot");
            check_sample(sample, exp_by_pass[out_n], "stream sample");
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        slot_t s;
        logic  aw_go, w_go;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(negedge clk);
            if (aw_go) awvalid = 1'b0;
            if (w_go) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge clk);
        check_word(32'(bresp), 32'd0, "bresp");
        // Registers took the write at the last edge
        if (addr < 8'd128) begin
            s = addr[6:4];
            case (addr[3:2])
                2'd0: inc_m[s] = data[`FM_PHASE_W-1:0];
                2'd1: att_m[s] = int'(data[9:0]);
                2'd2: begin
                    fb_m[s]  = int'(data[2:0]);
                    mod_m[s] = int'(data[8]);
                end
                default: ;
            endcase
        end
        // Response left pending one clock before it is taken
        @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        logic go;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        go = 1'b0;
        while (!go) begin
            go = arready;
            @(negedge clk);
        end
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        // Data must stay put while the response waits
        @(negedge clk);
        check_word(32'(rresp), 32'd0, "rresp");
        data = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] d;
        axi_read(addr, d);
        check_word(d, exp, $sformatf("read at %h", addr));
    endtask

    // Until every pass issued so far has streamed out, plus k more
    task automatic wait_passes(input int k);
        int target;
        target = pass_n + 8 * k + 8;
        while (out_n < target) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            tests_ok++;
            $display("Test %s: passed", name);
        end else begin
            tests_bad++;
            $display("Test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_readback();
        int          err0;
        logic [31:0] r;
        err0 = errors;
        wait_passes(2);
        for (int s = 0; s < `FM_SLOTS; s++) begin
            read_expect(8'(s * 16), 32'd0);
            read_expect(8'(s * 16 + 4), 32'h3ff);
            read_expect(8'(s * 16 + 8), 32'd0);
            read_expect(8'(s * 16 + 12), 32'd0);
        end
        for (int s = 0; s < `FM_SLOTS; s++) begin
            rng = xorshift(rng);
            r = rng;
            axi_write(8'(s * 16), r);
            read_expect(8'(s * 16), r & 32'hfffff);
            axi_write(8'(s * 16 + 4), r);
            read_expect(8'(s * 16 + 4), r & 32'h3ff);
            axi_write(8'(s * 16 + 8), r);
            read_expect(8'(s * 16 + 8), r & 32'h107);
        end
        // Past the map
        read_expect(8'h80, 32'd0);
        read_expect(8'hf4, 32'd0);
        report_test("register read-back", err0);
    endtask

    task automatic test_silence();
        int err0;
        err0 = errors;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            axi_write(8'(s * 16 + 4), 32'h3ff);
            axi_write(8'(s * 16 + 8), 32'd0);
        end
        wait_passes(4);
        repeat (128) begin
            @(negedge clk);
            if (sample_valid) check_sample(sample, '0, "silent sample");
        end
        for (int s = 0; s < `FM_SLOTS; s++) begin
            read_expect(8'(s * 16 + 12), 32'd0);
        end
        report_test("silence", err0);
    endtask

    task automatic test_sine();
        int err0, start, n0, n;
        err0 = errors;
        axi_write(8'h48, 32'd0);
        axi_write(8'h40, 32'd1024);
        axi_write(8'h44, 32'd0);
        start = pass_n + 8;
        wait_passes(520);
        n0 = start;
        while ((n0 - 1) % `FM_SLOTS != 4) n0++;
        // Half a period later the sign flips
        for (int j = 0; j < 8; j++) begin
            n = n0 + 8 * j;
            check_sample(got_by_pass[n + 8 * 512], -ref_sample(phase_by_pass[n], 0),
                         "half period");
        end
        report_test("unmodulated sine", err0);
    endtask

    task automatic test_atten();
        int err0, a, n0;
        err0 = errors;
        axi_write(8'h28, 32'd0);
        axi_write(8'h20, 32'd3072);
        repeat (6) begin
            rng = xorshift(rng);
            a = int'(rng % 32'd288);
            axi_write(8'h24, 32'(a));
            wait_passes(3);
            axi_write(8'h24, 32'(a + 32));
            n0 = pass_n;
            wait_passes(3);
            // 32 steps down is one octave, half the magnitude at the same phase
            for (int n = n0 + 1; n <= n0 + 24; n++) begin
                if ((n - 1) % `FM_SLOTS == 2) begin
                    check_sample(got_by_pass[n],
                                 sample_t'(ref_sample(phase_by_pass[n], a) / 2),
                                 "half amplitude");
                end
            end
        end
        report_test("attenuation", err0);
    endtask

    task automatic test_modulation();
        int err0;
        err0 = errors;
        axi_write(8'h08, 32'd0);
        axi_write(8'h00, 32'd1024);
        axi_write(8'h04, 32'd0);
        axi_write(8'h10, 32'd2048);
        axi_write(8'h14, 32'd0);
        axi_write(8'h18, 32'h100);
        wait_passes(40);
        // Back to a plain sine
        axi_write(8'h18, 32'd0);
        wait_passes(16);
        // Self-feedback on slot 2
        axi_write(8'h28, 32'd6);
        wait_passes(24);
        report_test("modulation", err0);
    endtask

    initial begin
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hf;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        pass_n = 0;
        out_n = 0;
        cyc = 0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        rng = 32'd30;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            acc_m[s] = '0;
            inc_m[s] = '0;
            att_m[s] = 1023;
            fb_m[s] = 0;
            mod_m[s] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        // Handshake and stream outputs idle in reset
        check_word(32'({awready, wready, bvalid, arready, rvalid, sample_valid}), 32'd0,
                   "outputs in reset");
        rst_n = 1'b1;
        test_readback();
        test_silence();
        test_sine();
        test_atten();
        test_modulation();
        $display("Tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

// File: all.f
+incdir+src
src/fm_pkg.sv
src/fm_delay_line.sv
src/fm_logsin_rom.sv
src/fm_exp_rom.sv
src/fm_phase_gen.sv
src/fm_operator.sv
src/fm_regs_axil.sv
src/fm_core_top.sv
verif/fm_core_asserts.sv
verif/fm_core_tb.sv

// File: Makefile
TOP = fm_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
